// File: all.f
+incdir+verilog
verilog/armCorePkg.sv
verilog/controlSequencer.sv
verilog/regFile.sv
verilog/operandShifter.sv
verilog/aluUnit.sv
verilog/conditionFlags.sv
verilog/armCore.sv
tb/armCoreChecker.sv
tb/armCoreTb.sv

// File: run.sh
#!/bin/bash
# build with Verilator and run; pass only when the pass message shows up

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module armCoreTb -Mdir obj_dir \
    && ./obj_dir/VarmCoreTb | tee /dev/stderr | grep -q "All tests passed!" \
    && echo "simulation PASSED" \
    || { echo "simulation FAILED"; exit 1; }

// File: tb/armCoreChecker.sv
module armCoreChecker (
    input  logic                     Clk,
    input  logic                     reset,
    input  armCorePkg::instrFields_t instr,
    input  logic                     instrValid,
    input  logic                     ready,
    input  logic                     retireValid,
    input  armCorePkg::retire_t      retire,
    input  armCorePkg::flags_t       flags,
    output int                       checkCount,
    output int                       errorCount,
    output int                       pending
);
    timeunit 1ns;
    timeprecision 100ps;
    import armCorePkg::*;

    logic [31:0] modelReg [16];
    flags_t      modelFlags;
    retire_t     expRetire [$];
    flags_t      expFlags [$];
    int          waitCycles;
    logic        acceptedLast;
    logic        retiredLast;
    logic        resetLast;

    function automatic logic condHolds(input logic [3:0] c, input flags_t f);
        case (c)
            4'h0: return f.z;
            4'h1: return !f.z;
            4'h2: return f.c;
            4'h3: return !f.c;
            4'h4: return f.n;
            4'h5: return !f.n;
            4'h6: return f.v;
            4'h7: return !f.v;
            4'h8: return f.c && !f.z;
            4'h9: return !f.c || f.z;
            4'hA: return f.n == f.v;
            4'hB: return f.n != f.v;
            4'hC: return !f.z && (f.n == f.v);
            4'hD: return f.z || (f.n != f.v);
            4'hE: return 1'b1;
            default: return 1'b0;  // NV
        endcase
    endfunction

    // reference model, one instruction at its accept edge
    function void modelStep(input logic [31:0] w);
        logic [31:0] m, a, b, r, imm32;
        logic [32:0] wide;
        logic        sc, co, ov, isArith, exec, wr, cin;
        int          amt;
        flags_t      nf;
        retire_t     e;
        m = modelReg[w[3:0]];
        a = modelReg[w[19:16]];
        cin = modelFlags.c;
        amt = int'(w[11:7]);
        imm32 = {24'b0, w[7:0]};
        if (w[25]) begin
            amt = 2 * int'(w[11:8]);
            b = (imm32 >> amt) | (imm32 << (32 - amt));
            sc = (amt == 0) ? cin : b[31];
        end else begin
            case (w[6:5])
                2'd0: begin
                    b = (amt == 0) ? m : m << amt;
                    sc = (amt == 0) ? cin : m[32 - amt];
                end
                2'd1: begin
                    b = (amt == 0) ? 32'b0 : m >> amt;  // amount 0 means 32
                    sc = (amt == 0) ? m[31] : m[amt - 1];
                end
                2'd2: begin
                    b = (amt == 0) ? {32{m[31]}} : 32'($signed(m) >>> amt);
                    sc = (amt == 0) ? m[31] : m[amt - 1];
                end
                default: begin
                    b = (amt == 0) ? {cin, m[31:1]} : (m >> amt) | (m << (32 - amt));
                    sc = (amt == 0) ? m[0] : m[amt - 1];
                end
            endcase
        end
        isArith = 1'b1;
        co = 1'b0;
        ov = 1'b0;
        r = '0;
        case (w[24:21])
            4'h4, 4'hB, 4'h5: begin
                wide = {1'b0, a} + {1'b0, b} + {32'b0, (w[24:21] == 4'h5) && cin};
                r = wide[31:0];
                co = wide[32];
                ov = (a[31] == b[31]) && (r[31] != a[31]);
            end
            4'h2, 4'hA, 4'h6: begin
                wide = {1'b0, b} + {32'b0, (w[24:21] == 4'h6) && !cin};  // total subtracted
                r = a - wide[31:0];
                co = {1'b0, a} >= wide;  // no borrow
                ov = (a[31] != b[31]) && (r[31] != a[31]);
            end
            4'h3, 4'h7: begin
                wide = {1'b0, a} + {32'b0, (w[24:21] == 4'h7) && !cin};
                r = b - wide[31:0];
                co = {1'b0, b} >= wide;
                ov = (b[31] != a[31]) && (r[31] != b[31]);
            end
            default: begin
                isArith = 1'b0;
                case (w[24:21])
                    4'h0, 4'h8: r = a & b;
                    4'h1, 4'h9: r = a ^ b;
                    4'hC:       r = a | b;
                    4'hD:       r = b;
                    4'hE:       r = a & ~b;
                    default:    r = ~b;
                endcase
            end
        endcase
        nf.n = r[31];
        nf.z = (r == 32'b0);
        nf.c = isArith ? co : sc;
        nf.v = isArith ? ov : modelFlags.v;
        exec = (w[27:26] == 2'b00) && !(!w[25] && w[4]) && condHolds(w[31:28], modelFlags);
        wr = exec && (w[24:23] != 2'b10);  // TST..CMN leave Rd alone
        e.executed = exec;
        e.wroteReg = wr;
        e.rd = w[15:12];
        e.data = wr ? r : 32'b0;
        if (wr) modelReg[w[15:12]] = r;
        if (exec && w[20]) modelFlags = nf;
        expRetire.push_back(e);
        expFlags.push_back(modelFlags);
    endfunction

    initial begin
        checkCount = 0;
        errorCount = 0;
        pending = 0;
    end

    always @(posedge Clk) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) modelReg[i] = '0;
            modelFlags = '0;
            expRetire.delete();
            expFlags.delete();
            waitCycles = 0;
            acceptedLast = 1'b0;
            retiredLast = 1'b0;
            resetLast = 1'b1;
        end else begin
            if (resetLast && (!ready || retireValid || flags != 4'b0)) begin
                $display("state after reset is wrong: ready, retireValid or flags");
                errorCount++;
            end
            if (acceptedLast && ready) begin
                $display("ready was high in the cycle after an accept");
                errorCount++;
            end
            if (retireValid && retiredLast) begin
                $display("retireValid stayed high for more than one cycle");
                errorCount++;
            end
            if (retireValid && expRetire.size() == 0) begin
                $display("retire seen with no accepted instruction");
                errorCount++;
            end else if (retireValid) begin
                checkCount++;
                if (retire !== expRetire[0]) begin
                    $display("mismatch retire: got %h expected %h", retire, expRetire[0]);
                    errorCount++;
                end
                if (flags !== expFlags[0]) begin
                    $display("mismatch flags: got %h expected %h", flags, expFlags[0]);
                    errorCount++;
                end
                void'(expRetire.pop_front());
                void'(expFlags.pop_front());
                waitCycles = 0;
            end
            if (expRetire.size() != 0) begin
                waitCycles++;
                if (waitCycles > 10) begin
                    $display("no retire within 10 cycles of an accepted instruction");
                    errorCount++;
                    void'(expRetire.pop_front());
                    void'(expFlags.pop_front());
                    waitCycles = 0;
                end
            end
            acceptedLast = instrValid && ready;
            if (acceptedLast) begin
                modelStep(instr);
                waitCycles = 0;
            end
            retiredLast = retireValid;
            resetLast = 1'b0;
        end
        pending = expRetire.size();
    end

endmodule

// File: tb/armCoreTb.sv
module armCoreTb;
    timeunit 1ns;
    timeprecision 100ps;
    import armCorePkg::*;

    logic         Clk;
    logic         reset;
    logic         instrValid;
    logic         ready;
    logic         retireValid;
    instrFields_t instr;
    retire_t      retire;
    flags_t       flags;
    int           checkCount;
    int           errorCount;
    int           pending;
    int           seed;
    int           lastChecks;
    int           lastErrors;

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    armCore i_armCore (
        .Clk(Clk), .reset(reset), .instr(instr), .instrValid(instrValid),
        .ready(ready), .retireValid(retireValid), .retire(retire), .flags(flags)
    );

    armCoreChecker i_armCoreChecker (
        .Clk(Clk), .reset(reset), .instr(instr), .instrValid(instrValid),
        .ready(ready), .retireValid(retireValid), .retire(retire), .flags(flags),
        .checkCount(checkCount), .errorCount(errorCount), .pending(pending)
    );

    function logic [31:0] nextRandom();
        return $random(seed);
    endfunction

    function automatic logic [31:0] dpWord(input logic [3:0] cond, input logic imm,
                                           input logic [3:0] op, input logic s,
                                           input logic [3:0] rn, input logic [3:0] rd,
                                           input logic [11:0] op2);
        return {cond, 2'b00, imm, op, s, rn, rd, op2};
    endfunction

    task automatic abortRun(input string why);
        $display("timeout: %s", why);
        $display("Test failures found");
        $finish;
    endtask

    // hold the word until the core takes it
    task automatic sendInstr(input logic [31:0] w);
        int waited;
        waited = 0;
        @(posedge Clk);
        instr <= w;
        instrValid <= 1'b1;
        do begin
            @(posedge Clk);
            waited++;
            if (waited > 20) abortRun("instruction not accepted within 20 cycles");
        end while (!ready);
        instrValid <= 1'b0;
    endtask

    task automatic finishTest(input string name);
        int waited;
        waited = 0;
        do begin
            @(negedge Clk);
            waited++;
            if (waited > 20) abortRun("core did not go idle after a test");
        end while (pending != 0 || !ready);
        $display("%s: checks %0d errors %0d", name, checkCount - lastChecks,
                 errorCount - lastErrors);
        lastChecks = checkCount;
        lastErrors = errorCount;
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] w;
        logic [4:0]  amt;
        logic [3:0]  setupOp;
        seed = 32'h699f3011;
        lastChecks = 0;
        lastErrors = 0;
        reset = 1'b1;
        instrValid = 1'b0;
        instr = '0;
        repeat (3) @(posedge Clk);
        reset <= 1'b0;

        for (int i = 0; i < 16; i++) begin  // MOV rotated immediates
            rnd = nextRandom();
            sendInstr(dpWord(4'hE, 1'b1, 4'hD, 1'b0, 4'h0, 4'(i), rnd[11:0]));
        end
        finishTest("resetAndMov");

        for (int op = 0; op < 16; op++) begin
            for (int k = 0; k < 4; k++) begin
                for (int a = 0; a < 4; a++) begin
                    rnd = nextRandom();
                    amt = (a == 0) ? 5'd0 : (a == 1) ? 5'd1 : (a == 2) ? 5'd31 : rnd[20:16];
                    w = dpWord(4'hE, 1'b0, 4'(op), rnd[31], rnd[3:0], rnd[7:4],
                               {amt, 2'(k), 1'b0, rnd[11:8]});
                    sendInstr(w);
                end
            end
        end
        finishTest("opsAndShifts");

        for (int i = 0; i < 40; i++) begin  // S set on every other one
            rnd = nextRandom();
            sendInstr(dpWord(4'hE, rnd[30], rnd[27:24], 1'(i % 2), rnd[3:0], rnd[7:4],
                             {rnd[23:17], rnd[16] & rnd[30], rnd[15:12]}));
        end
        finishTest("flagUpdate");

        for (int round = 0; round < 4; round++) begin
            for (int c = 0; c < 16; c++) begin
                rnd = nextRandom();
                setupOp = (rnd[1:0] == 2'd0) ? 4'h2 : (rnd[1:0] == 2'd1) ? 4'h4 : 4'hA;
                sendInstr(dpWord(4'hE, 1'b0, setupOp, 1'b1, rnd[7:4], rnd[11:8],
                                 {8'b0, rnd[15:12]}));
                rnd = nextRandom();
                sendInstr(dpWord(4'(c), rnd[30], rnd[27:24], rnd[29], rnd[3:0], rnd[7:4],
                                 {rnd[23:17], rnd[16] & rnd[30], rnd[11:8]}));
            end
        end
        finishTest("conditions");

        for (int i = 0; i < 40; i++) begin
            w = nextRandom();
            if (i < 20) begin
                if (w[27:26] == 2'b00) w[26] = 1'b1;  // not data processing
            end else begin
                w[27:25] = 3'b000;  // register-specified shift
                w[4] = 1'b1;
            end
            sendInstr(w);
        end
        finishTest("unsupported");

        for (int i = 0; i < 200; i++) begin
            rnd = nextRandom();
            repeat (int'(rnd[1:0])) @(posedge Clk);
            w = nextRandom();
            w[27:26] = 2'b00;
            if (!w[25]) w[4] = 1'b0;
            sendInstr(w);
        end
        finishTest("randomMix");

        $display("total checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: verilog/aluUnit.sv
`include "armCore_params.svh"

module aluUnit (
    input  armCorePkg::aluOp_t     opcode,
    input  logic                   sBit,
    input  logic [`DATA_WIDTH-1:0] rnData,
    input  logic [`DATA_WIDTH-1:0] shifterOut,
    input  logic                   shifterCarry,
    input  armCorePkg::flags_t     flagsIn,
    output logic [`DATA_WIDTH-1:0] result,
    output logic                   writesRd,
    output armCorePkg::flags_t     nextFlags
);
    import armCorePkg::*;

    logic [`DATA_WIDTH-1:0] addA;
    logic [`DATA_WIDTH-1:0] addB;
    logic                   addCin;
    logic                   isArith;
    logic [`DATA_WIDTH:0]   sum;
    logic                   overflow;
    flags_t                 opFlags;

    // one adder; subtraction is A + ~B + 1, borrow forms use C instead of 1
    always_comb begin
        addA    = rnData;
        addB    = shifterOut;
        addCin  = 1'b0;
        isArith = 1'b1;
        case (opcode)
            ADD, CMN: addCin = 1'b0;
            ADC:      addCin = flagsIn.c;
            SUB, CMP: begin
                addB   = ~shifterOut;
                addCin = 1'b1;
            end
            SBC: begin
                addB   = ~shifterOut;
                addCin = flagsIn.c;
            end
            RSB: begin
                addA   = shifterOut;
                addB   = ~rnData;
                addCin = 1'b1;
            end
            RSC: begin
                addA   = shifterOut;
                addB   = ~rnData;
                addCin = flagsIn.c;
            end
            default: isArith = 1'b0;
        endcase
    end

    assign sum      = {1'b0, addA} + {1'b0, addB} + {{`DATA_WIDTH{1'b0}}, addCin};
    assign overflow = (addA[`DATA_WIDTH-1] == addB[`DATA_WIDTH-1]) &&
                      (sum[`DATA_WIDTH-1] != addA[`DATA_WIDTH-1]);

    always_comb begin
        case (opcode)
            AND, TST: result = rnData & shifterOut;
            EOR, TEQ: result = rnData ^ shifterOut;
            ORR:      result = rnData | shifterOut;
            MOV:      result = shifterOut;
            BIC:      result = rnData & ~shifterOut;
            MVN:      result = ~shifterOut;
            default:  result = sum[`DATA_WIDTH-1:0];
        endcase
    end

    assign writesRd = !(opcode inside {TST, TEQ, CMP, CMN});  // compares only set flags

    always_comb begin
        opFlags.n = result[`DATA_WIDTH-1];
        opFlags.z = (result == '0);
        opFlags.c = isArith ? sum[`DATA_WIDTH] : shifterCarry;
        opFlags.v = isArith ? overflow : flagsIn.v;  // logical ops keep V
    end

    assign nextFlags = sBit ? opFlags : flagsIn;

endmodule

// File: verilog/armCore.sv
`include "armCore_params.svh"

module armCore (
    input  logic                     Clk,
    input  logic                     reset,
    input  armCorePkg::instrFields_t instr,
    input  logic                     instrValid,
    output logic                     ready,
    output logic                     retireValid,
    output armCorePkg::retire_t      retire,
    output armCorePkg::flags_t       flags
);

    armCorePkg::instrFields_t ir;
    armCorePkg::flags_t       nextFlags;
    logic [`DATA_WIDTH-1:0]   rnData;
    logic [`DATA_WIDTH-1:0]   rmData;
    logic [`DATA_WIDTH-1:0]   shifterOut;
    logic [`DATA_WIDTH-1:0]   result;
    logic                     shifterCarry;
    logic                     writesRd;
    logic                     condPass;
    logic                     regWrite;
    logic                     flagLoad;

    controlSequencer i_controlSequencer (
        .Clk         (Clk),
        .reset       (reset),
        .instr       (instr),
        .instrValid  (instrValid),
        .condPass    (condPass),
        .result      (result),
        .writesRd    (writesRd),
        .ir          (ir),
        .ready       (ready),
        .regWrite    (regWrite),
        .flagLoad    (flagLoad),
        .retireValid (retireValid),
        .retire      (retire)
    );

    regFile i_regFile (
        .Clk       (Clk),
        .reset     (reset),
        .regWrite  (regWrite),
        .rd        (ir.rd),
        .rn        (ir.rn),
        .rm        (ir.operand2[3:0]),
        .writeData (result),
        .rnData    (rnData),
        .rmData    (rmData)
    );

    operandShifter i_operandShifter (
        .ir           (ir),
        .rmData       (rmData),
        .carryIn      (flags.c),
        .shifterOut   (shifterOut),
        .shifterCarry (shifterCarry)
    );

    aluUnit i_aluUnit (
        .opcode       (ir.opcode),
        .sBit         (ir.sBit),
        .rnData       (rnData),
        .shifterOut   (shifterOut),
        .shifterCarry (shifterCarry),
        .flagsIn      (flags),
        .result       (result),
        .writesRd     (writesRd),
        .nextFlags    (nextFlags)
    );

    conditionFlags i_conditionFlags (
        .Clk       (Clk),
        .reset     (reset),
        .flagLoad  (flagLoad),
        .nextFlags (nextFlags),
        .cond      (ir.cond),
        .flags     (flags),
        .condPass  (condPass)
    );

endmodule

// File: verilog/armCorePkg.sv
`include "armCore_params.svh"

package armCorePkg;

    // data-processing opcodes in ARM numbering
    typedef enum logic [3:0] {
        AND = 4'h0,
        EOR = 4'h1,
        SUB = 4'h2,
        RSB = 4'h3,
        ADD = 4'h4,
        ADC = 4'h5,
        SBC = 4'h6,
        RSC = 4'h7,
        TST = 4'h8,
        TEQ = 4'h9,
        CMP = 4'hA,
        CMN = 4'hB,
        ORR = 4'hC,
        MOV = 4'hD,
        BIC = 4'hE,
        MVN = 4'hF
    } aluOp_t;

    typedef enum logic [1:0] {
        LSL = 2'd0,
        LSR = 2'd1,
        ASR = 2'd2,
        ROR = 2'd3
    } shiftKind_t;

    typedef struct packed {
        logic [3:0]                 cond;
        logic [1:0]                 cls;      // bits 27:26, 00 is data processing
        logic                       immFlag;  // bit 25
        aluOp_t                     opcode;
        logic                       sBit;
        logic [`REG_ADDR_WIDTH-1:0] rn;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [11:0]                operand2;
    } instrFields_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    // what one instruction left behind
    typedef struct packed {
        logic                       executed;
        logic                       wroteReg;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`DATA_WIDTH-1:0]     data;
    } retire_t;

endpackage

// File: verilog/armCore_params.svh
`ifndef ARMCORE_PARAMS_SVH
`define ARMCORE_PARAMS_SVH

// datapath width, registers and operands
`define DATA_WIDTH 32

// register file size
`define REG_COUNT 16
`define REG_ADDR_WIDTH 4

// condition field codes with fixed meaning
`define COND_ALWAYS 4'd14
`define COND_NEVER 4'd15

`endif

// File: verilog/conditionFlags.sv
`include "armCore_params.svh"

module conditionFlags (
    input  logic               Clk,
    input  logic               reset,
    input  logic               flagLoad,
    input  armCorePkg::flags_t nextFlags,
    input  logic [3:0]         cond,
    output armCorePkg::flags_t flags,
    output logic               condPass
);
    import armCorePkg::*;

    flags_t flagReg;

    always_ff @(posedge Clk) begin
        if (reset) begin
            flagReg <= '0;
        end else if (flagLoad) begin
            flagReg <= nextFlags;
        end
    end

    assign flags = flagReg;

    // condition table against stored flags
    always_comb begin
        case (cond)
            4'd0:         condPass = flagReg.z;                          // EQ
            4'd1:         condPass = !flagReg.z;                         // NE
            4'd2:         condPass = flagReg.c;                          // CS
            4'd3:         condPass = !flagReg.c;                         // CC
            4'd4:         condPass = flagReg.n;                          // MI
            4'd5:         condPass = !flagReg.n;                         // PL
            4'd6:         condPass = flagReg.v;                          // VS
            4'd7:         condPass = !flagReg.v;                         // VC
            4'd8:         condPass = flagReg.c && !flagReg.z;            // HI
            4'd9:         condPass = !flagReg.c || flagReg.z;            // LS
            4'd10:        condPass = (flagReg.n == flagReg.v);           // GE
            4'd11:        condPass = (flagReg.n != flagReg.v);           // LT
            4'd12:        condPass = !flagReg.z && (flagReg.n == flagReg.v);
            4'd13:        condPass = flagReg.z || (flagReg.n != flagReg.v);
            `COND_ALWAYS: condPass = 1'b1;
            `COND_NEVER:  condPass = 1'b0;
        endcase
    end

endmodule

// File: verilog/controlSequencer.sv
`include "armCore_params.svh"

module controlSequencer (
    input  logic                     Clk,
    input  logic                     reset,
    input  armCorePkg::instrFields_t instr,
    input  logic                     instrValid,
    input  logic                     condPass,
    input  logic [`DATA_WIDTH-1:0]   result,
    input  logic                     writesRd,
    output armCorePkg::instrFields_t ir,
    output logic                     ready,
    output logic                     regWrite,
    output logic                     flagLoad,
    output logic                     retireValid,
    output armCorePkg::retire_t      retire
);
    import armCorePkg::*;

    typedef enum logic {
        Idle,
        Exec
    } seqState_t;

    seqState_t state;
    retire_t   retireNext;
    logic      accept;
    logic      supported;
    logic      executes;

    assign ready  = (state == Idle);
    assign accept = ready && instrValid;

    // data processing only, register-specified shifts rejected
    assign supported = (ir.cls == 2'b00) && !(!ir.immFlag && ir.operand2[4]);
    assign executes  = supported && condPass;

    assign regWrite = (state == Exec) && executes && writesRd;
    assign flagLoad = (state == Exec) && executes && ir.sBit;

    always_ff @(posedge Clk) begin
        if (reset) begin
            state <= Idle;
        end else begin
            case (state)
                Idle: begin
                    if (accept) begin
                        state <= Exec;
                    end
                end
                default: state <= Idle;  // single execute cycle
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (accept) begin
            ir <= instr;
        end
    end

    always_comb begin
        retireNext.executed = executes;
        retireNext.wroteReg = executes && writesRd;
        retireNext.rd       = ir.rd;
        retireNext.data     = (executes && writesRd) ? result : '0;
    end

    // record taken at the same edge as the register write
    always_ff @(posedge Clk) begin
        if (reset) begin
            retireValid <= 1'b0;
        end else begin
            retireValid <= (state == Exec);
        end
    end

    always_ff @(posedge Clk) begin
        if (state == Exec) begin
            retire <= retireNext;
        end
    end

endmodule

// File: verilog/operandShifter.sv
`include "armCore_params.svh"

module operandShifter (
    input  armCorePkg::instrFields_t ir,
    input  logic [`DATA_WIDTH-1:0]   rmData,
    input  logic                     carryIn,
    output logic [`DATA_WIDTH-1:0]   shifterOut,
    output logic                     shifterCarry
);
    import armCorePkg::*;

    shiftKind_t                 kind;
    logic [4:0]                 shAmt;
    logic [4:0]                 rotAmt;
    logic [`DATA_WIDTH-1:0]     immVal;
    logic [2*`DATA_WIDTH-1:0]   immWide;
    logic [`DATA_WIDTH:0]       lslWide;  // carry lands in top bit
    logic [`DATA_WIDTH:0]       lsrWide;  // carry lands in bit 0
    logic [`DATA_WIDTH:0]       asrWide;
    logic [2*`DATA_WIDTH-1:0]   rorWide;

    assign kind   = shiftKind_t'(ir.operand2[6:5]);
    assign shAmt  = ir.operand2[11:7];
    assign rotAmt = {ir.operand2[11:8], 1'b0};  // twice the rotate field
    assign immVal = {{(`DATA_WIDTH-8){1'b0}}, ir.operand2[7:0]};

    // rotate right as a shift of the doubled word
    assign immWide = {immVal, immVal} >> rotAmt;
    assign lslWide = {1'b0, rmData} << shAmt;
    assign lsrWide = {rmData, 1'b0} >> shAmt;
    assign asrWide = $signed({rmData, 1'b0}) >>> shAmt;
    assign rorWide = {rmData, rmData} >> shAmt;

    always_comb begin
        if (ir.immFlag) begin
            shifterOut   = immWide[`DATA_WIDTH-1:0];
            shifterCarry = (rotAmt == 5'd0) ? carryIn : immWide[`DATA_WIDTH-1];
        end else if (shAmt == 5'd0) begin
            // zero amount encodes the special forms
            case (kind)
                LSL: begin
                    shifterOut   = rmData;
                    shifterCarry = carryIn;
                end
                LSR: begin
                    shifterOut   = '0;  // shift by 32
                    shifterCarry = rmData[`DATA_WIDTH-1];
                end
                ASR: begin
                    shifterOut   = {`DATA_WIDTH{rmData[`DATA_WIDTH-1]}};
                    shifterCarry = rmData[`DATA_WIDTH-1];
                end
                default: begin
                    shifterOut   = {carryIn, rmData[`DATA_WIDTH-1:1]};  // RRX
                    shifterCarry = rmData[0];
                end
            endcase
        end else begin
            case (kind)
                LSL:     {shifterCarry, shifterOut} = lslWide;
                LSR:     {shifterOut, shifterCarry} = lsrWide;
                ASR:     {shifterOut, shifterCarry} = asrWide;
                default: begin
                    shifterOut   = rorWide[`DATA_WIDTH-1:0];
                    shifterCarry = rorWide[`DATA_WIDTH-1];  // last bit rotated out
                end
            endcase
        end
    end

endmodule

// File: verilog/regFile.sv
`include "armCore_params.svh"

module regFile (
    input  logic                       Clk,
    input  logic                       reset,
    input  logic                       regWrite,
    input  logic [`REG_ADDR_WIDTH-1:0] rd,
    input  logic [`REG_ADDR_WIDTH-1:0] rn,
    input  logic [`REG_ADDR_WIDTH-1:0] rm,
    input  logic [`DATA_WIDTH-1:0]     writeData,
    output logic [`DATA_WIDTH-1:0]     rnData,
    output logic [`DATA_WIDTH-1:0]     rmData
);

    logic [`REG_COUNT-1:0]  cellEn;
    logic [`DATA_WIDTH-1:0] cellQ [`REG_COUNT];

    // write decoder, one enable per cell
    always_comb begin
        cellEn     = '0;
        cellEn[rd] = regWrite;
    end

    for (genvar i = 0; i < `REG_COUNT; i++) begin : gCell
        logic [`DATA_WIDTH-1:0] q;

        always_ff @(posedge Clk) begin
            if (reset) begin
                q <= '0;
            end else if (cellEn[i]) begin
                q <= writeData;
            end
        end

        assign cellQ[i] = q;
    end

    // two read ports
    assign rnData = cellQ[rn];
    assign rmData = cellQ[rm];

endmodule
